// File: design/bru_pkg.sv
`default_nettype none

package bru_pkg;

   // data and address width of the core
   localparam int unsigned xlen = 64;

   // ebreak target unless the top level overrides it
   localparam logic [xlen-1:0] trap_vector_default = 64'h8000_0000;

   // resolved control-flow operations
   typedef enum logic [3:0] {
      op_none,
      op_beq,
      op_bne,
      op_blt,
      op_bge,
      op_bltu,
      op_bgeu,
      op_jal,
      op_jalr,
      op_ebreak
   } cf_op_e;

   // one decoded operation, as it sits in the fifo
   typedef struct packed {
      cf_op_e          op;
      logic [xlen-1:0] pc;
      logic [xlen-1:0] imm;          // already sign extended
      logic [xlen-1:0] src1;
      logic [xlen-1:0] src2;
      logic            rs1_pending;  // jalr only
   } cf_op_t;

   // resolver output bundle
   typedef struct packed {
      logic [xlen-1:0] next_pc;
      logic            taken;
      cf_op_e          op;
   } cf_result_t;

   // fetch-side input bundle
   typedef struct packed {
      logic [31:0]     instr;
      logic [xlen-1:0] pc;
      logic [xlen-1:0] rs1_data;
      logic [xlen-1:0] rs2_data;
      logic            rs1_pending;  // rs1 waits on a load
   } instr_in_t;

endpackage

`default_nettype wire

// File: design/cf_decoder.sv
`default_nettype none

module cf_decoder (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   input  bru_pkg::instr_in_t in_data,
   output logic               dec_valid,
   output bru_pkg::cf_op_t    dec_op
);

   import bru_pkg::*;

   // rv major opcodes of interest
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;

   localparam logic [31:0] ebreak_word = 32'h0010_0073;

   logic [31:0]     instr;
   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [xlen-1:0] imm_b;
   logic [xlen-1:0] imm_j;
   logic [xlen-1:0] imm_i;
   cf_op_e          op_dec;
   cf_op_t          op_next;

   assign instr  = in_data.instr;
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];

   // immediates, sign bit is always instr[31]
   assign imm_b = {{(xlen-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{(xlen-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};

   always_comb begin
      op_dec = op_none;
      if (instr == ebreak_word) begin
         op_dec = op_ebreak;
      end else begin
         case (opcode)
            opc_branch: begin
               case (funct3)
                  3'b000:  op_dec = op_beq;
                  3'b001:  op_dec = op_bne;
                  3'b100:  op_dec = op_blt;
                  3'b101:  op_dec = op_bge;
                  3'b110:  op_dec = op_bltu;
                  3'b111:  op_dec = op_bgeu;
                  default: op_dec = op_none;  // 010/011 reserved
               endcase
            end
            opc_jal:  op_dec = op_jal;
            opc_jalr: op_dec = (funct3 == 3'b000) ? op_jalr : op_none;
            default:  op_dec = op_none;
         endcase
      end
   end

   always_comb begin
      op_next.op   = op_dec;
      op_next.pc   = in_data.pc;
      op_next.src1 = in_data.rs1_data;
      op_next.src2 = in_data.rs2_data;
      case (op_dec)
         op_jal:  op_next.imm = imm_j;
         op_jalr: op_next.imm = imm_i;
         op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: op_next.imm = imm_b;
         default: op_next.imm = '0;
      endcase
      // only jalr stalls on a pending load
      op_next.rs1_pending = in_data.rs1_pending && (op_dec == op_jalr);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         dec_op <= op_next;
      end
   end

endmodule

`default_nettype wire

// File: design/cf_op_fifo.sv
`default_nettype none

module cf_op_fifo #(
   parameter int depth = 4
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            push,
   input  bru_pkg::cf_op_t push_op,
   input  logic            pop,
   output bru_pkg::cf_op_t head,
   output logic            not_empty,
   output logic            full
);

   import bru_pkg::*;

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   cf_op_t           mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push && !full;  // push into a full fifo is lost
   assign do_pop  = pop && not_empty;

   assign head      = mem[rd_ptr];
   assign not_empty = (count != '0);
   assign full      = (count == cnt_w'(depth));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_op;
      end
   end

endmodule

`default_nettype wire

// File: design/next_pc_unit.sv
`default_nettype none

module next_pc_unit #(
   parameter logic [bru_pkg::xlen-1:0] trap_vector = bru_pkg::trap_vector_default
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     not_empty,
   input  bru_pkg::cf_op_t          head,
   input  logic [bru_pkg::xlen-1:0] fwd_data,
   output logic                     pop,
   output logic                     res_valid,
   output bru_pkg::cf_result_t      res
);

   import bru_pkg::*;

   typedef enum logic {
      st_run,
      st_wait_fwd
   } state_e;

   state_e          state;
   state_e          state_next;
   logic            head_pend_jalr;
   logic [xlen-1:0] rs1_val;
   logic [xlen-1:0] seq_pc;
   logic [xlen-1:0] br_pc;
   logic [xlen-1:0] jalr_sum;
   logic            cond;
   cf_result_t      res_next;

   assign head_pend_jalr = (head.op == op_jalr) && head.rs1_pending;

   always_comb begin
      state_next = state;
      pop        = 1'b0;
      case (state)
         st_run: begin
            if (not_empty && head_pend_jalr) begin
               state_next = st_wait_fwd;  // late rs1 arrives next cycle
            end else begin
               pop = not_empty;
            end
         end
         st_wait_fwd: begin
            pop        = not_empty;
            state_next = st_run;
         end
         default: state_next = st_run;
      endcase
   end

   // forwarded rs1 only in the wait state
   assign rs1_val  = (state == st_wait_fwd) ? fwd_data : head.src1;
   assign seq_pc   = head.pc + xlen'(4);
   assign br_pc    = head.pc + head.imm;
   assign jalr_sum = rs1_val + head.imm;

   always_comb begin
      case (head.op)
         op_beq:  cond = (head.src1 == head.src2);
         op_bne:  cond = (head.src1 != head.src2);
         op_blt:  cond = ($signed(head.src1) < $signed(head.src2));
         op_bge:  cond = ($signed(head.src1) >= $signed(head.src2));
         op_bltu: cond = (head.src1 < head.src2);
         op_bgeu: cond = (head.src1 >= head.src2);
         default: cond = 1'b0;
      endcase
   end

   always_comb begin
      res_next.op = head.op;
      case (head.op)
         op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
            res_next.next_pc = cond ? br_pc : seq_pc;
            res_next.taken   = cond;
         end
         op_jal: begin
            res_next.next_pc = br_pc;
            res_next.taken   = 1'b1;
         end
         op_jalr: begin
            res_next.next_pc = {jalr_sum[xlen-1:1], 1'b0};  // lsb cleared
            res_next.taken   = 1'b1;
         end
         op_ebreak: begin
            res_next.next_pc = trap_vector;
            res_next.taken   = 1'b1;
         end
         default: begin
            res_next.next_pc = seq_pc;
            res_next.taken   = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= st_run;
         res_valid <= 1'b0;
      end else begin
         state     <= state_next;
         res_valid <= pop;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         res <= res_next;
      end
   end

endmodule

`default_nettype wire

// File: design/branch_resolve_top.sv
`default_nettype none

module branch_resolve_top #(
   parameter int                       fifo_depth  = 4,
   parameter logic [bru_pkg::xlen-1:0] trap_vector = bru_pkg::trap_vector_default
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_valid,
   input  bru_pkg::instr_in_t       in_data,
   input  logic [bru_pkg::xlen-1:0] fwd_data,
   output logic                     full,
   output logic                     res_valid,
   output bru_pkg::cf_result_t      res
);

   import bru_pkg::*;

   logic   dec_valid;
   cf_op_t dec_op;
   cf_op_t head;
   logic   not_empty;
   logic   pop;

   cf_decoder i_decoder (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .dec_valid (dec_valid),
      .dec_op    (dec_op)
   );

   cf_op_fifo #(
      .depth (fifo_depth)
   ) i_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (dec_valid),
      .push_op   (dec_op),
      .pop       (pop),
      .head      (head),
      .not_empty (not_empty),
      .full      (full)
   );

   next_pc_unit #(
      .trap_vector (trap_vector)
   ) i_next_pc (
      .clk       (clk),
      .rst_n     (rst_n),
      .not_empty (not_empty),
      .head      (head),
      .fwd_data  (fwd_data),
      .pop       (pop),
      .res_valid (res_valid),
      .res       (res)
   );

endmodule

`default_nettype wire

// File: verif/branch_resolve_properties.sv
`default_nettype none

module branch_resolve_properties (
   input logic clk,
   input logic rst_n,
   input logic pop,
   input logic not_empty,
   input logic push,
   input logic full,
   input logic res_valid
);

   // pop only with something at the head
   pop_needs_data: assert property (
      @(posedge clk) disable iff (!rst_n) pop |-> not_empty
   ) else $error("pop while fifo empty");

   // pulse ends unless another pop is under way
   res_single_pulse: assert property (
      @(posedge clk) disable iff (!rst_n) (res_valid && !pop) |=> !res_valid
   ) else $error("res_valid held without a new pop");

   no_push_when_full: assert property (
      @(posedge clk) disable iff (!rst_n) full |-> !push
   ) else $error("push into a full fifo");

endmodule

bind cf_op_fifo branch_resolve_properties i_fifo_props (
   .clk       (clk),
   .rst_n     (rst_n),
   .pop       (pop),
   .not_empty (not_empty),
   .push      (push),
   .full      (full),
   .res_valid (1'b0)
);

bind next_pc_unit branch_resolve_properties i_npc_props (
   .clk       (clk),
   .rst_n     (rst_n),
   .pop       (pop),
   .not_empty (not_empty),
   .push      (1'b0),
   .full      (1'b0),
   .res_valid (res_valid)
);

`default_nettype wire

// File: verif/tb_branch_resolve.sv
`default_nettype none

module tb_branch_resolve;

   import bru_pkg::*;

   localparam int fifo_depth = 4;
   localparam int hold       = 10;  // drive delay after rising edge

   typedef struct {
      string           name;
      logic [31:0]     instr;
      logic [xlen-1:0] pc;
      logic [xlen-1:0] rs1;
      logic [xlen-1:0] rs2;
      logic            pend;
      logic [xlen-1:0] fwd;
      logic [xlen-1:0] exp_pc;
      logic            exp_taken;
      cf_op_e          exp_op;
      logic            no_gap;   // next push follows at once
   } vector_t;

   typedef struct {
      string           name;
      logic [xlen-1:0] next_pc;
      logic            taken;
      cf_op_e          op;
      logic            pend_jalr;
   } expect_t;

   logic            clk;
   logic            rst_n;
   logic            in_valid;
   instr_in_t       in_data;
   logic [xlen-1:0] fwd_data;
   logic            full;
   logic            res_valid;
   cf_result_t      res;

   vector_t         tbl[$];
   expect_t         exp_q[$];
   logic [xlen-1:0] fwd_q[$];
   logic [31:0]     lfsr_state = 32'h3488462b;
   int              n_push = 0;
   int              n_res = 0;
   logic            full_seen = 1'b0;
   logic            tbl_ready = 1'b0;

   branch_resolve_top #(
      .fifo_depth (fifo_depth)
   ) i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .fwd_data  (fwd_data),
      .full      (full),
      .res_valid (res_valid),
      .res       (res)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic fail_mismatch(input string name, input string what,
                                input logic [xlen-1:0] exp_v, input logic [xlen-1:0] act_v);
      $display("Mismatch %s %s expected %h actual %h", name, what, exp_v, act_v);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   function automatic logic [31:0] enc_branch(input logic [2:0] f3, input int imm);
      logic [12:0] i;
      i = imm[12:0];
      return {i[12], i[10:5], 5'd2, 5'd1, f3, i[4:1], i[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_jal(input int imm);
      logic [20:0] i;
      i = imm[20:0];
      return {i[20], i[10:1], i[11], i[19:12], 5'd1, 7'b1101111};
   endfunction

   function automatic logic [31:0] enc_jalr(input int imm);
      logic [11:0] i;
      i = imm[11:0];
      return {i, 5'd1, 3'b000, 5'd1, 7'b1100111};
   endfunction

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic take_lfsr_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic int next_gap();
      logic b0;
      logic b1;
      b0 = take_lfsr_bit();
      b1 = take_lfsr_bit();
      return int'({b1, b0});
   endfunction

   function automatic void add_vector(input string name, input logic [31:0] instr,
         input logic [xlen-1:0] pc, input logic [xlen-1:0] rs1, input logic [xlen-1:0] rs2,
         input logic pend, input logic [xlen-1:0] fwd, input logic [xlen-1:0] exp_pc,
         input logic exp_taken, input cf_op_e exp_op, input logic no_gap);
      vector_t v;
      v.name = name;
      v.instr = instr;
      v.pc = pc;
      v.rs1 = rs1;
      v.rs2 = rs2;
      v.pend = pend;
      v.fwd = fwd;
      v.exp_pc = exp_pc;
      v.exp_taken = exp_taken;
      v.exp_op = exp_op;
      v.no_gap = no_gap;
      tbl.push_back(v);
   endfunction

   task automatic build_table();
      logic [xlen-1:0] m1;
      m1 = '1;
      add_vector("beq_t", enc_branch(3'b000, 'h40), 'h1000, 5, 5, 0, 0, 'h1040, 1, op_beq, 0);
      add_vector("beq_nt", enc_branch(3'b000, 'h40), 'h1004, 5, 6, 0, 0, 'h1008, 0, op_beq, 0);
      add_vector("bne_t", enc_branch(3'b001, -'h10), 'h1008, 1, 2, 0, 0, 'h0ff8, 1, op_bne, 0);
      add_vector("bne_nt", enc_branch(3'b001, 'h20), 'h100c, 7, 7, 0, 0, 'h1010, 0, op_bne, 0);
      add_vector("blt_t", enc_branch(3'b100, 'h80), 'h1010, m1, 1, 0, 0, 'h1090, 1, op_blt, 0);
      add_vector("bltu_nt", enc_branch(3'b110, 'h80), 'h1014, m1, 1, 0, 0, 'h1018, 0,
                 op_bltu, 0);
      add_vector("bge_t", enc_branch(3'b101, 'h100), 'h1018, 3, 3, 0, 0, 'h1118, 1, op_bge, 0);
      add_vector("bge_nt", enc_branch(3'b101, 'h100), 'h101c, m1 - 4, 2, 0, 0, 'h1020, 0,
                 op_bge, 0);
      add_vector("bltu_t", enc_branch(3'b110, 'h8), 'h1020, 1, m1, 0, 0, 'h1028, 1, op_bltu, 0);
      add_vector("bgeu_t", enc_branch(3'b111, -'h24), 'h1024, m1, 1, 0, 0, 'h1000, 1,
                 op_bgeu, 0);
      add_vector("bgeu_nt", enc_branch(3'b111, 'h10), 'h1028, 1, 2, 0, 0, 'h102c, 0,
                 op_bgeu, 0);
      add_vector("blt_nt", enc_branch(3'b100, 'h10), 'h102c, 1, m1, 0, 0, 'h1030, 0, op_blt, 0);
      add_vector("jal_pos", enc_jal('h800), 'h2000, 0, 0, 0, 0, 'h2800, 1, op_jal, 0);
      add_vector("jal_neg", enc_jal(-'h1004), 'h2004, 0, 0, 0, 0, 'h1000, 1, op_jal, 0);
      add_vector("jalr", enc_jalr('h10), 'h3000, 'h4001, 0, 0, 0, 'h4010, 1, op_jalr, 0);
      add_vector("jalr_pend", enc_jalr('h7), 'h3004, 'hdead, 0, 1, 'h5000, 'h5006, 1,
                 op_jalr, 0);
      add_vector("ebreak", 32'h0010_0073, 'h3008, 0, 0, 0, 0, 'h8000_0000, 1, op_ebreak, 0);
      add_vector("add", 32'h0020_81b3, 'h300c, 1, 2, 0, 0, 'h3010, 0, op_none, 0);
      // burst of pending jalrs to fill the fifo
      for (int k = 0; k < 6; k++) begin
         add_vector($sformatf("burst_jalr%0d", k), enc_jalr('h4), 'h4000 + 4 * k, 'h1, 0, 1,
                    'h6000 + 'h100 * k, 'h6004 + 'h100 * k, 1, op_jalr, 1);
      end
      add_vector("burst_beq", enc_branch(3'b000, 'h20), 'h4100, 9, 9, 0, 0, 'h4120, 1,
                 op_beq, 1);
      add_vector("burst_bne", enc_branch(3'b001, 'h20), 'h4104, 9, 9, 0, 0, 'h4108, 0,
                 op_bne, 1);
      add_vector("burst_jal", enc_jal('h100), 'h4108, 0, 0, 0, 0, 'h4208, 1, op_jal, 0);
   endtask

   // result checks, sampled away from the rising edge
   initial begin
      expect_t e;
      forever begin
         @(negedge clk);
         if (full) full_seen = 1'b1;
         if (res_valid) begin
            assert (exp_q.size() > 0) else fail_run("result arrived with nothing outstanding");
            e = exp_q.pop_front();
            assert (res.next_pc == e.next_pc)
               else fail_mismatch(e.name, "next_pc", e.next_pc, res.next_pc);
            assert (res.taken == e.taken)
               else fail_mismatch(e.name, "taken", xlen'(e.taken), xlen'(res.taken));
            assert (res.op == e.op)
               else fail_mismatch(e.name, "op", xlen'(e.op), xlen'(res.op));
            if (e.pend_jalr) void'(fwd_q.pop_front());
            n_res++;
         end
      end
   end

   // late rs1 of the oldest outstanding pending jalr
   initial begin
      fwd_data = '0;
      forever begin
         @(posedge clk);
         #hold;
         fwd_data = (fwd_q.size() > 0) ? fwd_q[0] : '0;
      end
   end

   initial begin
      wait (tbl_ready);
      repeat (tbl.size() * 8 + 50 + 16) @(posedge clk);
      fail_run("watchdog expired before all results came out");
   end

   initial begin
      expect_t e;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_data = '0;
      build_table();
      tbl_ready = 1'b1;
      repeat (16) @(posedge clk);
      #hold;
      rst_n = 1'b1;
      // idle after reset
      repeat (5) begin
         @(negedge clk);
         assert (!res_valid) else fail_run("res_valid high after reset with no input");
         assert (!full) else fail_run("full high after reset");
      end
      @(posedge clk);
      #hold;
      foreach (tbl[i]) begin
         // one spare credit since a jalr wait cycle always ends in a pop
         while (full || (n_push - n_res) > fifo_depth) begin
            @(posedge clk);
            #hold;
         end
         in_data.instr = tbl[i].instr;
         in_data.pc = tbl[i].pc;
         in_data.rs1_data = tbl[i].rs1;
         in_data.rs2_data = tbl[i].rs2;
         in_data.rs1_pending = tbl[i].pend;
         in_valid = 1'b1;
         e.name = tbl[i].name;
         e.next_pc = tbl[i].exp_pc;
         e.taken = tbl[i].exp_taken;
         e.op = tbl[i].exp_op;
         e.pend_jalr = tbl[i].pend;
         exp_q.push_back(e);
         if (tbl[i].pend) fwd_q.push_back(tbl[i].fwd);
         n_push++;
         @(posedge clk);
         #hold;
         in_valid = 1'b0;
         if (!tbl[i].no_gap) begin
            repeat (next_gap()) begin
               @(posedge clk);
               #hold;
            end
         end
      end
      while (n_res < tbl.size()) @(posedge clk);
      repeat (4) @(posedge clk);
      assert (full_seen) else fail_run("full never went high during the burst");
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
design/bru_pkg.sv
design/cf_decoder.sv
design/cf_op_fifo.sv
design/next_pc_unit.sv
design/branch_resolve_top.sv
verif/branch_resolve_properties.sv
verif/tb_branch_resolve.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, decide by log search
verilator --binary --timing --assert -f sources.f --top-module tb_branch_resolve \
   --Mdir obj_dir -o sim_bin > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_bin > sim.log 2>&1 || echo "simulator returned nonzero"
grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation passed"
exit 0
